/* Bender.yml */
package:
  name: mini_core

sources:
  - src/core_pkg.sv
  - src/pipe_if.sv
  - src/reg_file.sv
  - src/decode_stage.sv
  - src/exec_stage.sv
  - src/result_stage.sv
  - src/mini_core_top.sv
  - target: simulation
    files:
      - bench/tb_core_properties.sv
      - bench/tb_core.sv

/* bench/tb_core.sv */
/*
 * tb_core
 * directed testbench for the three-stage core, with a credit-aware
 * instruction source, a trace consumer and a program-order reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int MAX_INSTR        = 120;
    localparam int CYCLES_PER_INSTR = 25;  // worst case stall plus credit return
    localparam int TIMEOUT_CYCLES   = MAX_INSTR * CYCLES_PER_INSTR;
    localparam int SETTLE_CYCLES    = 4 * core_pkg::IQ_DEPTH;

    logic               aclk;
    logic               arst_n;
    logic               instr_valid;
    core_pkg::word_t    instr;
    core_pkg::word_t    instr_pc;
    logic               instr_credit;
    logic               trace_valid;
    core_pkg::word_t    trace_pc;
    core_pkg::word_t    trace_wdata;
    logic [3:0]         trace_wen;
    core_pkg::reg_idx_t trace_wnum;
    logic               trace_credit;

    core_pkg::word_t    model_regs [core_pkg::NUM_REGS];
    core_pkg::word_t    exp_pc [$];
    core_pkg::word_t    exp_data [$];
    logic [3:0]         exp_wen [$];
    core_pkg::reg_idx_t exp_wnum [$];

    core_pkg::word_t lcg_state = 32'hd9e7;
    core_pkg::word_t next_pc   = 32'hbfc0_0000;
    int              src_credits = core_pkg::IQ_DEPTH;
    int              owed;         // trace credits the consumer still has to return
    int              hold_traces;
    int              cycle_count;
    logic            hold;         // consumer withholds trace credits
    string           test_name = "reset";

    mini_core_top u_dut (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_credit (instr_credit),
        .trace_valid  (trace_valid),
        .trace_pc     (trace_pc),
        .trace_wdata  (trace_wdata),
        .trace_wen    (trace_wen),
        .trace_wnum   (trace_wnum),
        .trace_credit (trace_credit)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input string what, input core_pkg::word_t expected,
                                input core_pkg::word_t actual);
        if (expected !== actual)
            abort_run($sformatf("Mismatch in %s %s: expected %h, actual %h",
                                test_name, what, expected, actual));
    endtask

    task automatic compare_idx(input string what, input core_pkg::reg_idx_t expected,
                               input core_pkg::reg_idx_t actual);
        if (expected !== actual)
            abort_run($sformatf("Mismatch in %s %s: expected %0d, actual %0d",
                                test_name, what, expected, actual));
    endtask

    task automatic compare_wen(input string what, input logic [3:0] expected,
                               input logic [3:0] actual);
        if (expected !== actual)
            abort_run($sformatf("Mismatch in %s %s: expected %b, actual %b",
                                test_name, what, expected, actual));
    endtask

    function automatic core_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic core_pkg::word_t encode_r(input logic [5:0] fn,
            input core_pkg::reg_idx_t rd, input core_pkg::reg_idx_t rs,
            input core_pkg::reg_idx_t rt);
        return {core_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic core_pkg::word_t encode_i(input logic [5:0] opc,
            input core_pkg::reg_idx_t rt, input core_pkg::reg_idx_t rs,
            input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // reference model runs at send time as retirement is in program order
    task automatic send_instr(input core_pkg::word_t w);
        core_pkg::reg_idx_t rs;
        core_pkg::reg_idx_t rt;
        core_pkg::reg_idx_t dst;
        core_pkg::word_t    a;
        core_pkg::word_t    b;
        core_pkg::word_t    res;
        logic               wr;
        rs  = w[25:21];
        rt  = w[20:16];
        a   = model_regs[rs];
        b   = model_regs[rt];
        dst = rt;
        res = '0;
        wr  = 1'b1;
        case (w[31:26])
            core_pkg::OPC_SPECIAL: begin
                dst = w[15:11];
                case (w[5:0])
                    core_pkg::FN_ADDU: res = a + b;
                    core_pkg::FN_SUBU: res = a - b;
                    core_pkg::FN_AND:  res = a & b;
                    core_pkg::FN_OR:   res = a | b;
                    core_pkg::FN_XOR:  res = a ^ b;
                    core_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:           wr  = 1'b0;
                endcase
            end
            core_pkg::OPC_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
            core_pkg::OPC_ORI:   res = a | {16'h0000, w[15:0]};
            core_pkg::OPC_LUI:   res = {w[15:0], 16'h0000};
            default:             wr  = 1'b0;
        endcase
        if (dst == '0) wr = 1'b0;
        if (wr) model_regs[dst] = res;
        exp_pc.push_back(next_pc);
        exp_data.push_back(res);
        exp_wen.push_back(wr ? core_pkg::WEN_ALL : 4'b0000);
        exp_wnum.push_back(dst);

        @(posedge aclk);
        while (src_credits == 0) begin  // source may only send on a credit
            instr_valid <= 1'b0;
            @(posedge aclk);
        end
        instr_valid <= 1'b1;
        instr       <= w;
        instr_pc    <= next_pc;
        src_credits--;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic load_reg(input core_pkg::reg_idx_t r, input core_pkg::word_t value);
        send_instr(encode_i(core_pkg::OPC_LUI, r, 5'd0, value[31:16]));
        send_instr(encode_i(core_pkg::OPC_ORI, r, r, value[15:0]));
    endtask

    task automatic idle_input();
        @(posedge aclk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        idle_input();
        while (exp_pc.size() != 0 || owed != 0) @(posedge aclk);
    endtask

    task automatic check_trace();
        core_pkg::word_t    e_pc;
        core_pkg::word_t    e_data;
        logic [3:0]         e_wen;
        core_pkg::reg_idx_t e_wnum;
        if (exp_pc.size() == 0) begin
            abort_run("trace_valid was seen with no instruction outstanding");
        end else begin
            e_pc   = exp_pc.pop_front();
            e_data = exp_data.pop_front();
            e_wen  = exp_wen.pop_front();
            e_wnum = exp_wnum.pop_front();
            compare_word("trace_pc", e_pc, trace_pc);
            compare_wen("trace_wen", e_wen, trace_wen);
            if (e_wen != 4'b0000) begin  // data and number only count on a write
                compare_word("trace_wdata", e_data, trace_wdata);
                compare_idx("trace_wnum", e_wnum, trace_wnum);
            end
        end
    endtask

    task automatic rtype_ops();
        core_pkg::word_t va;
        core_pkg::word_t vb;
        test_name = "rtype";
        repeat (3) begin
            va = lcg_next();
            vb = lcg_next();
            load_reg(5'd1, va);
            load_reg(5'd2, vb);
            send_instr(encode_r(core_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_SUBU, 5'd4, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_AND,  5'd5, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_OR,   5'd6, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_XOR,  5'd7, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_SLT,  5'd8, 5'd1, 5'd2));
            send_instr(encode_r(core_pkg::FN_SLT,  5'd9, 5'd2, 5'd1));
        end
        wait_drained();
    endtask

    task automatic itype_ops();
        test_name = "itype";
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd10, 5'd0,  16'hfffb));  // -5
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd11, 5'd10, 16'h8000));
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd12, 5'd11, 16'h7fff));
        send_instr(encode_i(core_pkg::OPC_ORI,   5'd13, 5'd0,  16'h8001));  // no sign fill
        send_instr(encode_i(core_pkg::OPC_ORI,   5'd14, 5'd10, 16'h00f0));
        send_instr(encode_i(core_pkg::OPC_LUI,   5'd15, 5'd0,  16'hdead));
        send_instr(encode_i(core_pkg::OPC_ORI,   5'd15, 5'd15, 16'hbeef));
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd16, 5'd15, 16'hffff));
        wait_drained();
    endtask

    task automatic dependent_chain();
        test_name = "chain";
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd17, 5'd0, 16'h0003));
        repeat (5) send_instr(encode_r(core_pkg::FN_ADDU, 5'd17, 5'd17, 5'd17));
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd19, 5'd0, 16'h0007));
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd19, 5'd0, 16'h0009));  // waw
        send_instr(encode_i(core_pkg::OPC_ORI,   5'd19, 5'd19, 16'h0010));
        send_instr(encode_r(core_pkg::FN_XOR,    5'd18, 5'd19, 5'd17));
        wait_drained();
    endtask

    task automatic r0_and_unknown();
        test_name = "r0_unknown";
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd0, 5'd0, 16'h1234));
        send_instr(encode_r(core_pkg::FN_ADDU, 5'd0, 5'd17, 5'd19));
        send_instr({6'h3f, 5'd1, 5'd2, 16'h55aa});                  // unknown opcode
        send_instr(encode_r(6'h3f, 5'd3, 5'd1, 5'd2));              // unknown funct
        send_instr(encode_r(core_pkg::FN_OR, 5'd20, 5'd0, 5'd0));
        send_instr(encode_r(core_pkg::FN_ADDU, 5'd21, 5'd0, 5'd17));
        send_instr(encode_i(core_pkg::OPC_ADDIU, 5'd22, 5'd0, 16'h0000));
        wait_drained();
    endtask

    task automatic credit_backpressure();
        core_pkg::word_t r;
        test_name = "backpressure";
        @(posedge aclk);
        hold <= 1'b1;
        hold_traces = 0;
        // enough to fill result credits, execute and the whole queue
        for (int i = 0; i < core_pkg::TRACE_CREDITS + 1 + core_pkg::IQ_DEPTH; i++) begin
            r = lcg_next();
            send_instr(encode_i(core_pkg::OPC_ADDIU, core_pkg::reg_idx_t'(23 + i),
                                5'd17, r[15:0]));
        end
        idle_input();
        while (hold_traces < core_pkg::TRACE_CREDITS) @(posedge aclk);
        repeat (SETTLE_CYCLES) @(posedge aclk);  // nothing more may retire here
        if (src_credits != 0) begin
            abort_run("source still holds credits while the core is back-pressured");
        end else begin
            hold <= 1'b0;
            wait_drained();
        end
    endtask

    // trace consumer returns one credit per cycle unless holding
    always @(posedge aclk) begin
        if (!arst_n) trace_credit <= 1'b0;
        else         trace_credit <= !hold && owed > 0;
    end

    // outputs are sampled mid-cycle
    always @(negedge aclk) begin
        if (arst_n) begin
            if (instr_credit) begin
                src_credits++;
                if (src_credits > core_pkg::IQ_DEPTH)
                    abort_run("instr_credit returned more credits than were spent");
            end
            owed = owed + (trace_valid ? 1 : 0) - (trace_credit ? 1 : 0);
            if (trace_valid) begin
                if (hold) hold_traces++;
                if (hold_traces > core_pkg::TRACE_CREDITS)
                    abort_run("core retired more instructions than it had trace credits");
                check_trace();
            end
        end
    end

    always @(negedge aclk) begin
        if (u_dut.u_props.fail_seen)
            abort_run("an assertion on the core ports failed");
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("timeout, the core stopped retiring instructions");
    end

    initial begin
        for (int i = 0; i < core_pkg::NUM_REGS; i++) model_regs[i] = '0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        trace_credit = 1'b0;
        hold         = 1'b0;
        repeat (4) @(posedge aclk);
        arst_n <= 1'b1;
        rtype_ops();
        itype_ops();
        dependent_chain();
        r0_and_unknown();
        credit_backpressure();
        if (src_credits == core_pkg::IQ_DEPTH) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("core kept instruction credits after every instruction retired");
        end
    end

endmodule

`default_nettype wire

/* bench/tb_core_properties.sv */
/*
 * tb_core_properties
 * trace port and reset checks on the core's top-level ports
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core_properties (
    input logic               aclk,
    input logic               arst_n,
    input logic               instr_credit,
    input logic               trace_valid,
    input logic [3:0]         trace_wen,
    input core_pkg::reg_idx_t trace_wnum
);

    logic fail_seen = 1'b0;

    // byte enables come as all or nothing
    wen_legal: assert property (@(posedge aclk) disable iff (!arst_n)
        trace_wen == 4'b0000 || trace_wen == core_pkg::WEN_ALL)
        else begin
            $error("trace_wen is neither zero nor all bytes");
            fail_seen = 1'b1;
        end

    wen_has_dst: assert property (@(posedge aclk) disable iff (!arst_n)
        trace_wen != 4'b0000 |-> trace_wnum != '0)
        else begin
            $error("trace write reported to r0");
            fail_seen = 1'b1;
        end

    quiet_after_reset: assert property (@(posedge aclk)
        $rose(arst_n) |-> !trace_valid && !instr_credit)
        else begin
            $error("core output active in the first cycle after reset");
            fail_seen = 1'b1;
        end

endmodule

bind mini_core_top tb_core_properties u_props (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .instr_credit (instr_credit),
    .trace_valid  (trace_valid),
    .trace_wen    (trace_wen),
    .trace_wnum   (trace_wnum)
);

`default_nettype wire

/* sources.f */
src/core_pkg.sv
src/pipe_if.sv
src/reg_file.sv
src/decode_stage.sv
src/exec_stage.sv
src/result_stage.sv
src/mini_core_top.sv
bench/tb_core_properties.sv
bench/tb_core.sv

/* src/core_pkg.sv */
/*
 * core_pkg
 * shared widths, ALU opcodes, MIPS field codes and credit depths
 * for the three-stage integer core
 */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;     // data and pc
    typedef logic [4:0]  reg_idx_t;  // gpr number

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    localparam int NUM_REGS      = 32;
    localparam int IQ_DEPTH      = 4;   // also the source's credits after reset
    localparam int TRACE_CREDITS = 2;

    // derived counter widths
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int TCRED_W  = $clog2(TRACE_CREDITS + 1);

    // major opcodes, instr[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct codes under SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [3:0] WEN_ALL = 4'b1111;  // full word written

endpackage

`default_nettype wire

/* src/decode_stage.sv */
/*
 * decode_stage
 * credit-fed instruction queue, decoder, busy-bit scoreboard
 * and register operand read toward execute
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  core_pkg::word_t    instr,
    input  core_pkg::word_t    instr_pc,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_idx,
    output logic               instr_credit,
    output core_pkg::reg_idx_t rd_idx_a,
    output core_pkg::reg_idx_t rd_idx_b,
    input  core_pkg::word_t    rd_data_a,
    input  core_pkg::word_t    rd_data_b,
    dx_if.sender               dx
);

    core_pkg::word_t                q_instr [core_pkg::IQ_DEPTH];
    core_pkg::word_t                q_pc    [core_pkg::IQ_DEPTH];
    logic [core_pkg::IQ_PTR_W-1:0]  wr_ptr;
    logic [core_pkg::IQ_PTR_W-1:0]  rd_ptr;
    logic [core_pkg::IQ_PTR_W:0]    q_count;

    core_pkg::word_t    head;
    logic [5:0]         opc;
    logic [5:0]         funct;
    logic [15:0]        imm;
    core_pkg::reg_idx_t rs;
    core_pkg::reg_idx_t rt;
    core_pkg::reg_idx_t rd;

    core_pkg::alu_op_e  dec_op;
    core_pkg::reg_idx_t dec_dst;
    core_pkg::word_t    dec_b;
    logic               dec_wr;
    logic               use_rs;
    logic               use_rt;

    logic [core_pkg::NUM_REGS-1:0] busy;
    logic [core_pkg::NUM_REGS-1:0] busy_eff;  // minus the reg retiring now
    logic                          hazard;
    logic                          issue;

    // instruction queue pointers and fill count
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= (wr_ptr == core_pkg::IQ_PTR_W'(core_pkg::IQ_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == core_pkg::IQ_PTR_W'(core_pkg::IQ_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({instr_valid, issue})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (instr_valid) begin
            q_instr[wr_ptr] <= instr;
            q_pc[wr_ptr]    <= instr_pc;
        end
    end

    assign head  = q_instr[rd_ptr];
    assign opc   = head[31:26];
    assign rs    = head[25:21];
    assign rt    = head[20:16];
    assign rd    = head[15:11];
    assign imm   = head[15:0];
    assign funct = head[5:0];

    always_comb begin
        dec_op  = core_pkg::ALU_NONE;
        dec_dst = rt;
        dec_b   = rd_data_b;
        dec_wr  = 1'b0;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        case (opc)
            core_pkg::OPC_SPECIAL: begin
                dec_dst = rd;
                dec_wr  = 1'b1;
                use_rs  = 1'b1;
                use_rt  = 1'b1;
                case (funct)
                    core_pkg::FN_ADDU: dec_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: dec_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  dec_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   dec_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  dec_op = core_pkg::ALU_XOR;
                    core_pkg::FN_SLT:  dec_op = core_pkg::ALU_SLT;
                    default: begin  // unknown funct retires as a no-op
                        dec_wr = 1'b0;
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                    end
                endcase
            end
            core_pkg::OPC_ADDIU: begin
                dec_op = core_pkg::ALU_ADD;
                dec_b  = {{16{imm[15]}}, imm};
                dec_wr = 1'b1;
                use_rs = 1'b1;
            end
            core_pkg::OPC_ORI: begin
                dec_op = core_pkg::ALU_OR;
                dec_b  = {16'h0000, imm};
                dec_wr = 1'b1;
                use_rs = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                dec_op = core_pkg::ALU_LUI;
                dec_b  = {imm, 16'h0000};
                dec_wr = 1'b1;
            end
            default: ;
        endcase
        if (dec_dst == '0) dec_wr = 1'b0;  // r0 writes are dropped
    end

    // scoreboard
    always_comb begin
        for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
            busy_eff[i] = busy[i] && !(wb_en && wb_idx == core_pkg::reg_idx_t'(i));
        end
    end

    assign hazard = (use_rs && busy_eff[rs]) ||
                    (use_rt && busy_eff[rt]) ||
                    (dec_wr && busy_eff[dec_dst]);  // keeps writes in order

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                if (issue && dec_wr && dec_dst == core_pkg::reg_idx_t'(i))
                    busy[i] <= 1'b1;  // set wins over a same-cycle clear
                else if (wb_en && wb_idx == core_pkg::reg_idx_t'(i))
                    busy[i] <= 1'b0;
            end
        end
    end

    assign rd_idx_a = rs;
    assign rd_idx_b = rt;

    assign dx.valid     = (q_count != '0) && !hazard;
    assign dx.alu_op    = dec_op;
    assign dx.operand_a = rd_data_a;
    assign dx.operand_b = dec_b;
    assign dx.dst       = dec_dst;
    assign dx.wr_en     = dec_wr;
    assign dx.pc        = q_pc[rd_ptr];

    assign issue        = dx.valid && dx.ready;
    assign instr_credit = issue;  // one credit back per issued slot

endmodule

`default_nettype wire

/* src/exec_stage.sv */
/*
 * exec_stage
 * integer ALU plus a one-entry output register toward result
 */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic  aclk,
    input  logic  arst_n,
    dx_if.receiver dx,
    xr_if.sender   xr
);

    core_pkg::word_t    alu_out;
    logic               out_valid;
    core_pkg::word_t    out_result;
    core_pkg::reg_idx_t out_dst;
    logic               out_wr;
    core_pkg::word_t    out_pc;

    always_comb begin
        case (dx.alu_op)
            core_pkg::ALU_ADD: alu_out = dx.operand_a + dx.operand_b;
            core_pkg::ALU_SUB: alu_out = dx.operand_a - dx.operand_b;  // wraps
            core_pkg::ALU_AND: alu_out = dx.operand_a & dx.operand_b;
            core_pkg::ALU_OR:  alu_out = dx.operand_a | dx.operand_b;
            core_pkg::ALU_XOR: alu_out = dx.operand_a ^ dx.operand_b;
            core_pkg::ALU_SLT: alu_out = {31'b0, $signed(dx.operand_a) < $signed(dx.operand_b)};
            core_pkg::ALU_LUI: alu_out = dx.operand_b;  // already shifted by decode
            default:           alu_out = '0;
        endcase
    end

    // take a new one when empty or when the held one leaves this cycle
    assign dx.ready = !out_valid || xr.ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (dx.ready) begin
            out_valid <= dx.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (dx.valid && dx.ready) begin
            out_result <= alu_out;
            out_dst    <= dx.dst;
            out_wr     <= dx.wr_en;
            out_pc     <= dx.pc;
        end
    end

    assign xr.valid  = out_valid;
    assign xr.result = out_result;
    assign xr.dst    = out_dst;
    assign xr.wr_en  = out_wr;
    assign xr.pc     = out_pc;

endmodule

`default_nettype wire

/* src/mini_core_top.sv */
/*
 * mini_core_top
 * three-stage integer core, credit-based instruction input
 * and golden-trace output
 */
`timescale 1ns/1ps
`default_nettype none

module mini_core_top (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  core_pkg::word_t    instr,
    input  core_pkg::word_t    instr_pc,
    output logic               instr_credit,
    output logic               trace_valid,
    output core_pkg::word_t    trace_pc,
    output core_pkg::word_t    trace_wdata,
    output logic [3:0]         trace_wen,
    output core_pkg::reg_idx_t trace_wnum,
    input  logic               trace_credit
);

    core_pkg::reg_idx_t rd_idx_a;
    core_pkg::reg_idx_t rd_idx_b;
    core_pkg::word_t    rd_data_a;
    core_pkg::word_t    rd_data_b;
    logic               wb_en;      // retire write port
    core_pkg::reg_idx_t wb_idx;
    core_pkg::word_t    wb_data;

    dx_if u_dx ();
    xr_if u_xr ();

    decode_stage u_decode (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .instr_credit (instr_credit),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .dx           (u_dx.sender)
    );

    exec_stage u_exec (
        .aclk   (aclk),
        .arst_n (arst_n),
        .dx     (u_dx.receiver),
        .xr     (u_xr.sender)
    );

    result_stage u_result (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .trace_credit (trace_credit),
        .trace_valid  (trace_valid),
        .trace_pc     (trace_pc),
        .trace_wdata  (trace_wdata),
        .trace_wen    (trace_wen),
        .trace_wnum   (trace_wnum),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .xr           (u_xr.receiver)
    );

    reg_file u_regs (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

`default_nettype wire

/* src/pipe_if.sv */
/*
 * stage-to-stage handshakes
 * dx_if carries decoded operands, xr_if carries ALU results
 */
`timescale 1ns/1ps
`default_nettype none

interface dx_if;
    logic               valid;
    logic               ready;
    core_pkg::alu_op_e  alu_op;
    core_pkg::word_t    operand_a;
    core_pkg::word_t    operand_b;  // rt value or extended immediate
    core_pkg::reg_idx_t dst;
    logic               wr_en;
    core_pkg::word_t    pc;

    modport sender (output valid, alu_op, operand_a, operand_b, dst, wr_en, pc,
                    input  ready);
    modport receiver (input  valid, alu_op, operand_a, operand_b, dst, wr_en, pc,
                      output ready);
endinterface

interface xr_if;
    logic               valid;
    logic               ready;
    core_pkg::word_t    result;
    core_pkg::reg_idx_t dst;
    logic               wr_en;
    core_pkg::word_t    pc;

    modport sender (output valid, result, dst, wr_en, pc,
                    input  ready);
    modport receiver (input  valid, result, dst, wr_en, pc,
                      output ready);
endinterface

`default_nettype wire

/* src/reg_file.sv */
/*
 * reg_file
 * 32 x 32 gpr array, two reads and one write, r0 hard zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               aclk,
    input  logic               arst_n,
    input  core_pkg::reg_idx_t rd_idx_a,
    input  core_pkg::reg_idx_t rd_idx_b,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_idx,
    input  core_pkg::word_t    wb_data,
    output core_pkg::word_t    rd_data_a,
    output core_pkg::word_t    rd_data_b
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    always_comb begin
        if (rd_idx_a == '0)                      rd_data_a = '0;
        else if (wb_en && wb_idx == rd_idx_a)    rd_data_a = wb_data;
        else                                     rd_data_a = regs[rd_idx_a];

        if (rd_idx_b == '0)                      rd_data_b = '0;
        else if (wb_en && wb_idx == rd_idx_b)    rd_data_b = wb_data;
        else                                     rd_data_b = regs[rd_idx_b];
    end

endmodule

`default_nettype wire

/* src/result_stage.sv */
/*
 * result_stage
 * writeback register feeding the gpr file and the credit-limited
 * golden-trace port
 */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               trace_credit,
    output logic               trace_valid,
    output core_pkg::word_t    trace_pc,
    output core_pkg::word_t    trace_wdata,
    output logic [3:0]         trace_wen,
    output core_pkg::reg_idx_t trace_wnum,
    output logic               wb_en,
    output core_pkg::reg_idx_t wb_idx,
    output core_pkg::word_t    wb_data,
    xr_if.receiver             xr
);

    logic [core_pkg::TCRED_W-1:0] credits;
    logic                         take;
    logic                         valid_q;
    logic                         wr_q;
    core_pkg::word_t              pc_q;
    core_pkg::word_t              data_q;
    core_pkg::reg_idx_t           dst_q;

    assign xr.ready = (credits != '0);  // retire only while holding a trace credit
    assign take     = xr.valid && xr.ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= core_pkg::TCRED_W'(core_pkg::TRACE_CREDITS);
        end else begin
            case ({take, trace_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // spent and returned together
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            valid_q <= take;
            wr_q    <= take && xr.wr_en;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            pc_q   <= xr.pc;
            data_q <= xr.result;
            dst_q  <= xr.dst;
        end
    end

    // gpr write lands at the end of the trace cycle
    assign wb_en   = valid_q && wr_q;
    assign wb_idx  = dst_q;
    assign wb_data = data_q;

    assign trace_valid = valid_q;
    assign trace_pc    = pc_q;
    assign trace_wdata = data_q;
    assign trace_wen   = wb_en ? core_pkg::WEN_ALL : 4'b0000;
    assign trace_wnum  = dst_q;

endmodule

`default_nettype wire
